// File: tb.f
+incdir+source
source/dw_host_pkg.sv
source/dw_store_pkg.sv
source/dw_regfile.sv
source/dw_cmd_seq.sv
source/dw_irq.sv
source/dw_top.sv
bench/dw_props.sv
bench/dw_tb.sv

// File: Bender.yml
package:
  name: dw_disk

sources:
  - include_dirs:
      - source
    files:
      - source/dw_host_pkg.sv
      - source/dw_store_pkg.sv
      - source/dw_regfile.sv
      - source/dw_cmd_seq.sv
      - source/dw_irq.sv
      - source/dw_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/dw_props.sv
      - bench/dw_tb.sv

// File: bench/dw_tb.sv
// testbench of the disk controller
// clock, reset, storage model, bus tasks, random checks and report
`include "dw_defs.svh"

module dw_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam dw_store_pkg::blk_addr_t OFFSET = 27'h100;
   localparam dw_store_pkg::blk_addr_t LIMIT  = 27'h10000;   // error at or above

   logic wb_clk_i, wb_rst_i, wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
   logic [4:0] wb_adr_i;
   logic [1:0] wb_sel_i;
   dw_host_pkg::word_t wb_dat_i, wb_dat_o;
   logic iack_i, irq_o, sdreq_o, sdack_i;
   dw_store_pkg::store_req_t store_req;
   dw_store_pkg::store_rsp_t store_rsp;
   logic st_idle, st_done, st_err;   // storage model outputs

   dw_host_pkg::word_t sbuf [`DW_SECTOR_WORDS];     // storage side sector buffer
   dw_host_pkg::word_t disk [logic [34:0]];          // {block, word}
   dw_host_pkg::word_t wr_data [`DW_SECTOR_WORDS];
   dw_store_pkg::blk_addr_t last_blk;
   integer seed;
   int errors, checks, tests, err_start;

   dw_top i_dut (
      .wb_clk_i, .wb_rst_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_cyc_i, .wb_stb_i,
      .wb_we_i, .wb_sel_i, .wb_ack_o, .iack_i, .irq_o, .sdreq_o, .sdack_i,
      .store_req_o(store_req), .store_rsp_i(store_rsp), .start_offset_i(OFFSET)
   );

   assign store_rsp = {st_idle, st_done, st_err, sbuf[store_req.buf_addr]};

   initial begin
      wb_clk_i = 1'b0;
      forever #4 wb_clk_i = ~wb_clk_i;
   end

   // ********************
   // storage model
   // ********************
   always @(posedge wb_clk_i) begin
      if (store_req.wr) sbuf[store_req.buf_addr] <= store_req.wdata;
   end

   // grant after 0 to 3 cycles
   initial begin : grant_model
      int d;
      forever begin
         @(negedge wb_clk_i);
         if (sdreq_o && !sdack_i) begin
            d = {$random(seed)} % 4;
            repeat (d) @(negedge wb_clk_i);
            sdack_i = 1'b1;
         end else if (!sdreq_o) begin
            sdack_i = 1'b0;
         end
      end
   end

   initial begin : transfer_model
      int d;
      int n;
      logic [34:0] key;
      forever begin
         @(negedge wb_clk_i);
         if (store_req.start && !st_done) begin
            st_idle = 1'b0;
            d = 2 + {$random(seed)} % 19;   // 2 to 20 cycles
            repeat (d) @(negedge wb_clk_i);
            last_blk = store_req.blk_addr;
            st_err = (last_blk >= LIMIT);
            for (int i = 0; i < `DW_SECTOR_WORDS && !st_err; i++) begin
               key = {last_blk, i[7:0]};
               if (store_req.write_mode) disk[key] = sbuf[i];
               else if (disk.exists(key)) sbuf[i] = disk[key];
               else sbuf[i] = key[15:0] ^ key[31:16] ^ {13'b0, key[34:32]} ^ 16'ha5c3;  // fill
            end
            st_done = 1'b1;
            for (n = 0; n < 100 && store_req.start; n++) @(negedge wb_clk_i);
            assert (!store_req.start) else begin
               $display("Storage start still high 100 cycles after done");
               errors++;
            end
            st_done = 1'b0;
            st_err  = 1'b0;
            st_idle = 1'b1;
         end
      end
   end

   // ********************
   // bus access and checks
   // ********************
   task automatic bus_xfer(input dw_host_pkg::reg_off_t off, input logic we,
                           input dw_host_pkg::word_t dat, output dw_host_pkg::word_t rdat);
      int n;
      rdat = '0;
      @(negedge wb_clk_i);
      {wb_cyc_i, wb_stb_i, wb_we_i, wb_sel_i} = {1'b1, 1'b1, we, 2'b11};
      wb_adr_i = {off, 1'b0};
      wb_dat_i = dat;
      for (n = 0; n < 20; n++) begin
         @(negedge wb_clk_i);
         if (wb_ack_o) break;
      end
      assert (wb_ack_o) else begin
         $display("Bus cycle at offset %0d got no ack", off);
         errors++;
      end
      rdat = wb_dat_o;
      {wb_cyc_i, wb_stb_i, wb_we_i} = '0;
   endtask

   task automatic reg_write(input dw_host_pkg::reg_off_t off, input dw_host_pkg::word_t dat);
      dw_host_pkg::word_t dummy;
      bus_xfer(off, 1'b1, dat, dummy);
   endtask

   task automatic reg_read(input dw_host_pkg::reg_off_t off, output dw_host_pkg::word_t dat);
      bus_xfer(off, 1'b0, '0, dat);
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   // read a register until one bit is set
   task automatic poll_bit(input dw_host_pkg::reg_off_t off, input int bitn, input string what);
      dw_host_pkg::word_t v = '0;
      for (int n = 0; n < 400; n++) begin
         reg_read(off, v);
         if (v[bitn]) break;
      end
      checks++;
      assert (v[bitn]) else begin
         $display("Timed out waiting for %s", what);
         errors++;
      end
   endtask

   task automatic wait_irq(input logic level);
      int n;
      for (n = 0; n < 100 && irq_o !== level; n++) @(negedge wb_clk_i);
      checks++;
      assert (irq_o === level) else begin
         $display("Timed out waiting for irq_o to go %0b", level);
         errors++;
      end
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("test %0d %s: %s", tests, name, (errors == err_start) ? "ok" : "FAILED");
      err_start = errors;
   endtask

   // sets cyl, head and 1-based sector and returns the expected block address
   task automatic set_chs(input int cyl, input int hd, input int sec,
                          output dw_store_pkg::blk_addr_t blk);
      reg_write(`DW_REG_CYL, cyl);
      reg_write(`DW_REG_HD, hd);
      reg_write(`DW_REG_SEC, sec);
      blk = OFFSET + (cyl << 7) + (hd << 4) + ((sec - 1) & 15);
   endtask

   // ********************
   // test sequence
   // ********************
   initial begin
      dw_host_pkg::word_t v;
      dw_store_pkg::blk_addr_t blk;
      int cyl, hd, sec;
      seed = 32'h7457;
      {errors, checks, tests, err_start} = '0;
      {wb_cyc_i, wb_stb_i, wb_we_i, wb_sel_i, wb_adr_i, wb_dat_i} = '0;
      {iack_i, sdack_i, st_done, st_err} = '0;
      st_idle = 1'b1;
      last_blk = '0;
      wb_rst_i = 1'b1;
      repeat (5) @(posedge wb_clk_i);
      @(negedge wb_clk_i);
      wb_rst_i = 1'b0;

      // registers after reset
      reg_read(`DW_REG_ID, v);
      check_val("ID", v, 16'o401);
      reg_read(`DW_REG_STRS, v);
      check_val("STRS.rqa", v[0], 1);
      cyl = {$random(seed)} % 1024;
      hd  = {$random(seed)} % 8;
      sec = 1 + {$random(seed)} % 16;
      set_chs(cyl, hd, sec, blk);
      reg_read(`DW_REG_CYL, v);
      check_val("CYL", v, cyl);
      reg_read(`DW_REG_HD, v);
      check_val("HD", v, hd);
      reg_read(`DW_REG_SEC, v);
      check_val("SEC", v, sec - 1);
      end_test("reset and readback");

      // recalibrate with interrupt handshake
      reg_write(`DW_REG_STRS, 16'h0040);
      reg_write(`DW_REG_CS2, `DW_CMD_RECAL);
      reg_read(`DW_REG_STRS, v);
      check_val("STRS.rqa", v[0], 1);
      wait_irq(1'b1);
      iack_i = 1'b1;
      wait_irq(1'b0);
      repeat (4) begin
         @(negedge wb_clk_i);
         check_val("irq_o", irq_o, 0);   // held off during iack
      end
      iack_i = 1'b0;
      wait_irq(1'b1);
      iack_i = 1'b1;
      wait_irq(1'b0);
      iack_i = 1'b0;
      reg_write(`DW_REG_STRS, 16'h0000);
      end_test("recalibrate and irq");

      // write a random sector and read it back
      set_chs({$random(seed)} % 256, {$random(seed)} % 8, 1 + {$random(seed)} % 16, blk);
      reg_write(`DW_REG_CS2, `DW_CMD_WRITE);
      poll_bit(`DW_REG_CS2, 11, "write drq");
      for (int i = 0; i < `DW_SECTOR_WORDS; i++) begin
         wr_data[i] = $random(seed);
         reg_write(`DW_REG_BUF, wr_data[i]);
      end
      poll_bit(`DW_REG_STRS, 0, "write done");
      check_val("write blk_addr", last_blk, blk);
      for (int i = 0; i < `DW_SECTOR_WORDS; i++) sbuf[i] = ~sbuf[i];   // spoil the buffer
      reg_write(`DW_REG_CS2, `DW_CMD_READ);
      poll_bit(`DW_REG_CS2, 11, "read drq");
      check_val("read blk_addr", last_blk, blk);
      for (int i = 0; i < `DW_SECTOR_WORDS; i++) begin
         reg_read(`DW_REG_BUF, v);
         check_val("BUF", v, wr_data[i]);
      end
      reg_read(`DW_REG_STRS, v);
      check_val("STRS.rqa", v[0], 1);
      end_test("sector write and read");

      // unknown command
      reg_write(`DW_REG_CS2, 8'o77);
      reg_read(`DW_REG_ERR, v);
      check_val("ERR.cmderr", v[10], 1);
      reg_read(`DW_REG_CS2, v);
      check_val("CS2.cmderr", v[8], 1);
      end_test("bad command");

      // storage errors past the limit
      reg_write(`DW_REG_STRS, 16'h0008);   // soft reset clears cmderr
      set_chs(1023, 7, 16, blk);
      reg_write(`DW_REG_CS2, `DW_CMD_READ);
      poll_bit(`DW_REG_STRS, 0, "failed read");
      reg_read(`DW_REG_CS2, v);
      check_val("CS2.cmderr", v[8], 1);
      reg_write(`DW_REG_CS2, `DW_CMD_WRITE);
      poll_bit(`DW_REG_CS2, 11, "write drq");
      for (int i = 0; i < `DW_SECTOR_WORDS; i++) reg_write(`DW_REG_BUF, $random(seed));
      poll_bit(`DW_REG_STRS, 0, "failed write");
      reg_read(`DW_REG_CS2, v);
      check_val("CS2.write_error", v[13], 1);
      end_test("storage errors");

      // soft reset with ide set in the same write
      reg_write(`DW_REG_STRS, 16'h0048);
      reg_read(`DW_REG_STRS, v);   // ahead of SEC, whose read clears rqa
      check_val("STRS.ide", v[6], 0);
      check_val("STRS.rqa", v[0], 1);
      reg_read(`DW_REG_CYL, v);
      check_val("CYL", v, 0);
      reg_read(`DW_REG_HD, v);
      check_val("HD", v, 0);
      reg_read(`DW_REG_SEC, v);
      check_val("SEC", v, 0);
      end_test("soft reset");

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// File: bench/dw_props.sv
// bound handshake checks for the disk controller
// bus ack, storage start / done, port request and interrupt mask

module dw_props (
   input logic clk_i,
   input logic rst_i,
   input logic ack_i,
   input logic start_i,
   input logic done_i,
   input logic sdreq_i,
   input logic irq_i,
   input logic ide_i
);
   timeunit 1ns;
   timeprecision 100ps;

   // single cycle ack, then a gap
   ack_gap: assert property (@(posedge clk_i) disable iff (rst_i) ack_i |=> !ack_i)
      else $error("wishbone ack high on two cycles in a row");

   start_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      (start_i && !done_i) |=> start_i)
      else $error("storage start dropped before done");

   // port must be ours while a transfer runs
   start_owned: assert property (@(posedge clk_i) disable iff (rst_i) start_i |-> sdreq_i)
      else $error("storage start without port request");

   irq_masked: assert property (@(posedge clk_i) disable iff (rst_i) !ide_i |-> !irq_i)
      else $error("irq high while interrupts disabled");

endmodule

bind dw_top dw_props i_props (
   .clk_i(wb_clk_i), .rst_i(wb_rst_i), .ack_i(wb_ack_o),
   .start_i(store_req_o.start), .done_i(store_rsp_i.done),
   .sdreq_i(sdreq_o), .irq_i(irq_o), .ide_i(ide)
);

// File: source/dw_top.sv
// disk controller top level
// register file, command sequencer and interrupt requester

module dw_top (
   input  logic                      wb_clk_i,
   input  logic                      wb_rst_i,
   input  logic [4:0]                wb_adr_i,
   input  dw_host_pkg::word_t        wb_dat_i,
   output dw_host_pkg::word_t        wb_dat_o,
   input  logic                      wb_cyc_i,
   input  logic                      wb_stb_i,
   input  logic                      wb_we_i,
   input  logic [1:0]                wb_sel_i,
   output logic                      wb_ack_o,
   input  logic                      iack_i,
   output logic                      irq_o,
   output logic                      sdreq_o,
   input  logic                      sdack_i,
   output dw_store_pkg::store_req_t  store_req_o,
   input  dw_store_pkg::store_rsp_t  store_rsp_i,
   input  dw_store_pkg::blk_addr_t   start_offset_i   // bank base on the storage
);

   dw_host_pkg::status_t status;
   dw_host_pkg::chs_t    chs;
   dw_host_pkg::cmd_t    cmd;
   dw_host_pkg::word_t   buf_wdata;
   logic ide, buf_rd, buf_wr, rqa_clr, soft_rst;

   // bus side
   dw_regfile u_regfile (
      .wb_clk_i, .wb_rst_i, .wb_adr_i, .wb_dat_i, .wb_dat_o,
      .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_sel_i, .wb_ack_o,
      .status_i(status), .rdata_i(store_rsp_i.rdata),
      .chs_o(chs), .cmd_o(cmd), .ide_o(ide),
      .buf_rd_o(buf_rd), .buf_wr_o(buf_wr), .buf_wdata_o(buf_wdata),
      .rqa_clr_o(rqa_clr), .soft_rst_o(soft_rst)
   );

   // storage side
   dw_cmd_seq u_cmd_seq (
      .wb_clk_i, .wb_rst_i, .soft_rst_i(soft_rst),
      .chs_i(chs), .cmd_i(cmd), .buf_rd_i(buf_rd), .buf_wr_i(buf_wr),
      .buf_wdata_i(buf_wdata), .rqa_clr_i(rqa_clr), .start_offset_i,
      .status_o(status), .sdreq_o, .sdack_i, .store_req_o, .store_rsp_i
   );

   dw_irq u_irq (
      .wb_clk_i, .wb_rst_i, .soft_rst_i(soft_rst),
      .ide_i(ide), .status_i(status), .iack_i, .irq_o
   );

endmodule

// File: source/dw_irq.sv
// interrupt requester of the disk controller
// request / acknowledge handshake on rqa and drq

module dw_irq (
   input  logic                  wb_clk_i,
   input  logic                  wb_rst_i,
   input  logic                  soft_rst_i,
   input  logic                  ide_i,      // interrupt enable
   input  dw_host_pkg::status_t  status_i,
   input  logic                  iack_i,     // from the cpu
   output logic                  irq_o
);

   dw_host_pkg::irq_state_e state;
   logic irq_q;
   logic pending;

   assign pending = ide_i & (status_i.rqa | status_i.drq);

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state <= dw_host_pkg::irq_idle;
         irq_q <= 1'b0;
      end else if (soft_rst_i) begin
         state <= dw_host_pkg::irq_idle;
         irq_q <= 1'b0;
      end else begin
         case (state)
            dw_host_pkg::irq_idle: begin
               irq_q <= pending;
               if (pending) state <= dw_host_pkg::irq_req;
            end
            dw_host_pkg::irq_req: begin
               if (!ide_i) begin
                  irq_q <= 1'b0;   // request withdrawn
                  state <= dw_host_pkg::irq_idle;
               end else if (iack_i) begin
                  irq_q <= 1'b0;
                  state <= dw_host_pkg::irq_wait;
               end
            end
            dw_host_pkg::irq_wait: begin
               // cpu still in the vector cycle
               if (!iack_i) state <= dw_host_pkg::irq_idle;
            end
            default: state <= dw_host_pkg::irq_idle;
         endcase
      end
   end

   // masked at once when ide drops
   assign irq_o = irq_q & ide_i;

endmodule

// File: source/dw_cmd_seq.sv
// command sequencer of the disk controller
// recalibrate, read and write flows, buffer word counter, status and block address
`include "dw_defs.svh"

module dw_cmd_seq (
   input  logic                      wb_clk_i,
   input  logic                      wb_rst_i,
   input  logic                      soft_rst_i,
   input  dw_host_pkg::chs_t         chs_i,
   input  dw_host_pkg::cmd_t         cmd_i,
   input  logic                      buf_rd_i,
   input  logic                      buf_wr_i,
   input  dw_host_pkg::word_t        buf_wdata_i,
   input  logic                      rqa_clr_i,
   input  dw_store_pkg::blk_addr_t   start_offset_i,
   output dw_host_pkg::status_t      status_o,
   output logic                      sdreq_o,      // port request
   input  logic                      sdack_i,      // port grant
   output dw_store_pkg::store_req_t  store_req_o,
   input  dw_store_pkg::store_rsp_t  store_rsp_i
);

   dw_store_pkg::seq_state_e state;
   dw_store_pkg::buf_addr_t  wcnt;   // buffer word counter
   logic rqa, drq, busy, cmderr, write_error;
   logic start, write_mode;
   logic last_word;
   logic grant_ok;   // port ours and storage free

   assign last_word = (wcnt == dw_store_pkg::buf_addr_t'(`DW_SECTOR_WORDS - 1));
   assign grant_ok  = sdreq_o & sdack_i & store_rsp_i.idle & ~store_rsp_i.done;

   // ********************
   // sequencer
   // ********************
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state <= dw_store_pkg::seq_idle;
         wcnt <= '0;
         rqa <= 1'b1;   // controller comes up done
         {drq, busy, cmderr, write_error} <= '0;
         {start, write_mode, sdreq_o} <= '0;
      end else if (soft_rst_i) begin
         state <= dw_store_pkg::seq_idle;
         wcnt <= '0;
         rqa <= 1'b1;
         {drq, busy, cmderr, write_error} <= '0;
         {start, write_mode, sdreq_o} <= '0;
      end else begin
         if (rqa_clr_i) rqa <= 1'b0;   // sets below take priority
         case (state)
            dw_store_pkg::seq_idle: begin
               if (cmd_i.go) begin
                  cmderr <= 1'b0;
                  case (cmd_i.code)
                     `DW_CMD_RECAL: rqa <= 1'b1;   // nothing to move
                     `DW_CMD_READ: begin
                        sdreq_o <= 1'b1;
                        busy    <= 1'b1;
                        state   <= dw_store_pkg::seq_rd_wait;
                     end
                     `DW_CMD_WRITE: begin
                        drq   <= 1'b1;   // host fills the buffer first
                        wcnt  <= '0;
                        state <= dw_store_pkg::seq_wr_fill;
                     end
                     default: begin
                        cmderr <= 1'b1;
                        rqa    <= 1'b1;
                     end
                  endcase
               end
            end
            dw_store_pkg::seq_rd_wait: begin
               if (!start) begin
                  if (grant_ok) begin
                     start      <= 1'b1;
                     write_mode <= 1'b0;
                  end
               end else if (store_rsp_i.done) begin
                  start   <= 1'b0;
                  busy    <= 1'b0;
                  sdreq_o <= 1'b0;   // release the port
                  if (store_rsp_i.error) begin
                     cmderr <= 1'b1;
                     rqa    <= 1'b1;
                     state  <= dw_store_pkg::seq_finish;
                  end else begin
                     wcnt  <= '0;
                     drq   <= 1'b1;
                     state <= dw_store_pkg::seq_rd_out;
                  end
               end
            end
            dw_store_pkg::seq_rd_out: begin
               if (buf_rd_i) begin
                  wcnt <= wcnt + 1'b1;
                  if (last_word) begin   // 256th word gone
                     drq   <= 1'b0;
                     rqa   <= 1'b1;
                     state <= dw_store_pkg::seq_idle;
                  end
               end
            end
            dw_store_pkg::seq_wr_fill: begin
               if (buf_wr_i) begin
                  wcnt <= wcnt + 1'b1;   // word written this edge
                  if (last_word) begin
                     drq     <= 1'b0;
                     sdreq_o <= 1'b1;
                     busy    <= 1'b1;
                     state   <= dw_store_pkg::seq_wr_req;
                  end
               end
            end
            dw_store_pkg::seq_wr_req: begin
               if (grant_ok) begin
                  start      <= 1'b1;
                  write_mode <= 1'b1;
                  state      <= dw_store_pkg::seq_wr_wait;
               end
            end
            dw_store_pkg::seq_wr_wait: begin
               if (store_rsp_i.done) begin
                  {start, write_mode, busy, sdreq_o} <= '0;
                  rqa <= 1'b1;
                  if (store_rsp_i.error) write_error <= 1'b1;   // sticky
                  state <= dw_store_pkg::seq_finish;
               end
            end
            dw_store_pkg::seq_finish: begin
               if (!store_rsp_i.done) state <= dw_store_pkg::seq_idle;
            end
            default: state <= dw_store_pkg::seq_idle;
         endcase
      end
   end

   // ********************
   // storage port and status
   // ********************
   always_comb begin
      store_req_o.start      = start;
      store_req_o.write_mode = write_mode;
      // offset + cyl : head : low 4 sector bits
      store_req_o.blk_addr   = start_offset_i +
         dw_store_pkg::blk_addr_t'({chs_i.cyl, chs_i.head, chs_i.sec[3:0]});
      store_req_o.buf_addr   = wcnt;
      store_req_o.wdata      = buf_wdata_i;
      store_req_o.wr         = buf_wr_i & (state == dw_store_pkg::seq_wr_fill);
   end

   assign status_o.rqa         = rqa;
   assign status_o.drq         = drq;
   assign status_o.busy        = busy;
   assign status_o.cmderr      = cmderr;
   assign status_o.write_error = write_error;

endmodule

// File: source/dw_regfile.sv
// wishbone slave of the disk controller
// register storage, readback mux, buffer strobes and soft reset request
`include "dw_defs.svh"

module dw_regfile (
   input  logic                  wb_clk_i,
   input  logic                  wb_rst_i,
   input  logic [4:0]            wb_adr_i,     // byte address
   input  dw_host_pkg::word_t    wb_dat_i,
   output dw_host_pkg::word_t    wb_dat_o,
   input  logic                  wb_cyc_i,
   input  logic                  wb_stb_i,
   input  logic                  wb_we_i,
   input  logic [1:0]            wb_sel_i,
   output logic                  wb_ack_o,
   input  dw_host_pkg::status_t  status_i,
   input  dw_host_pkg::word_t    rdata_i,      // sector buffer word
   output dw_host_pkg::chs_t     chs_o,
   output dw_host_pkg::cmd_t     cmd_o,
   output logic                  ide_o,
   output logic                  buf_rd_o,
   output logic                  buf_wr_o,
   output dw_host_pkg::word_t    buf_wdata_o,
   output logic                  rqa_clr_o,
   output logic                  soft_rst_o
);

   dw_host_pkg::reg_off_t off;
   dw_host_pkg::word_t    rd_mux;
   logic reply;     // first cycle of a strobe
   logic rd_req;
   logic wr_req;    // full word writes only
   logic ready;     // drive ready, no transfer in progress

   assign off    = wb_adr_i[4:1];   // word registers
   assign reply  = wb_cyc_i & wb_stb_i & ~wb_ack_o;
   assign rd_req = reply & ~wb_we_i;
   assign wr_req = reply & wb_we_i & (wb_sel_i == 2'b11);
   assign ready  = ~status_i.busy;

   // ********************
   // bus acknowledge
   // ********************
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wb_ack_o <= 1'b0;
      end else begin
         wb_ack_o <= reply;   // one cycle, then a gap
      end
   end

   // ********************
   // control registers and strobes
   // ********************
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         chs_o      <= '0;
         cmd_o      <= '0;
         ide_o      <= 1'b0;
         buf_rd_o   <= 1'b0;
         buf_wr_o   <= 1'b0;
         rqa_clr_o  <= 1'b0;
         soft_rst_o <= 1'b0;
      end else if (soft_rst_o) begin
         // same state as hardware reset, ack keeps running
         chs_o      <= '0;
         cmd_o      <= '0;
         ide_o      <= 1'b0;
         buf_rd_o   <= 1'b0;
         buf_wr_o   <= 1'b0;
         rqa_clr_o  <= 1'b0;
         soft_rst_o <= 1'b0;
      end else begin
         // strobes line up with the ack
         cmd_o.go   <= wr_req & (off == `DW_REG_CS2);
         buf_rd_o   <= rd_req & (off == `DW_REG_BUF);
         buf_wr_o   <= wr_req & (off == `DW_REG_BUF);
         rqa_clr_o  <= (rd_req | wr_req) & ((off == `DW_REG_SEC) | (off == `DW_REG_CS2));
         soft_rst_o <= wr_req & (off == `DW_REG_STRS) & wb_dat_i[3];
         if (wr_req) begin
            case (off)
               `DW_REG_SEC:  chs_o.sec  <= wb_dat_i[`DW_SEC_W-1:0] - 1'b1;  // host counts from 1
               `DW_REG_CYL:  chs_o.cyl  <= wb_dat_i[`DW_CYL_W-1:0];
               `DW_REG_HD:   chs_o.head <= wb_dat_i[`DW_HD_W-1:0];
               `DW_REG_CS2:  cmd_o.code <= wb_dat_i[`DW_CODE_W-1:0];
               `DW_REG_STRS: ide_o      <= wb_dat_i[6];
               default: ;   // read only or unmapped
            endcase
         end
      end
   end

   // ********************
   // readback
   // ********************
   always_comb begin
      case (off)
         `DW_REG_ID:   rd_mux = `DW_ID_VALUE;
         `DW_REG_ERR:  rd_mux = {5'b0, status_i.cmderr, 10'b0};
         `DW_REG_SEC:  rd_mux = {11'b0, chs_o.sec};
         `DW_REG_BUF:  rd_mux = rdata_i;               // word at the current counter
         `DW_REG_CYL:  rd_mux = {6'b0, chs_o.cyl};
         `DW_REG_HD:   rd_mux = {13'b0, chs_o.head};
         `DW_REG_CS2: begin
            // ready twice, seek complete and drive ready
            rd_mux = {1'b0, ready, status_i.write_error, ready,
                      status_i.drq, 2'b0, status_i.cmderr, 8'b0};
         end
         `DW_REG_STRS: begin
            rd_mux = {status_i.busy, 7'b0, 1'b1, ide_o, 5'b0, status_i.rqa};  // bit 7 buffer ready
         end
         default:      rd_mux = '0;
      endcase
   end

   // data registers, loaded on the ack edge
   always_ff @(posedge wb_clk_i) begin
      if (rd_req) begin
         wb_dat_o <= rd_mux;
      end
      if (wr_req && off == `DW_REG_BUF) begin
         buf_wdata_o <= wb_dat_i;
      end
   end

endmodule

// File: source/dw_store_pkg.sv
// storage side types of the disk controller
// block and buffer addresses, port structs and sequencer states
`include "dw_defs.svh"

package dw_store_pkg;

   typedef logic [`DW_BLK_W-1:0]  blk_addr_t;  // storage block number
   typedef logic [`DW_BUF_AW-1:0] buf_addr_t;  // word within the sector

   // controller to storage
   typedef struct packed {
      logic                start;       // held until done
      logic                write_mode;  // 0 read, 1 write
      blk_addr_t           blk_addr;
      buf_addr_t           buf_addr;
      dw_host_pkg::word_t  wdata;
      logic                wr;          // buffer write strobe
   } store_req_t;

   // storage to controller
   typedef struct packed {
      logic                idle;   // ready to take a start
      logic                done;
      logic                error;  // valid with done
      dw_host_pkg::word_t  rdata;  // buffer word at buf_addr
   } store_rsp_t;

   typedef enum logic [2:0] {
      seq_idle,
      seq_rd_wait,   // storage read running
      seq_rd_out,    // host drains the buffer
      seq_wr_fill,   // host fills the buffer
      seq_wr_req,    // waiting for grant
      seq_wr_wait,   // storage write running
      seq_finish     // wait for done to fall
   } seq_state_e;

endpackage

// File: source/dw_host_pkg.sv
// host side types of the disk controller
// register words, chs fields, command, status and irq states
`include "dw_defs.svh"

package dw_host_pkg;

   // ********************
   // plain vectors
   // ********************
   typedef logic [`DW_WORD_W-1:0] word_t;     // bus data word
   typedef logic [`DW_OFF_W-1:0]  reg_off_t;  // word offset in the bank
   typedef logic [`DW_CYL_W-1:0]  cyl_t;
   typedef logic [`DW_HD_W-1:0]   head_t;
   typedef logic [`DW_SEC_W-1:0]  sec_t;      // zero based once stored

   // disk position as the host sets it up
   typedef struct packed {
      cyl_t  cyl;
      head_t head;
      sec_t  sec;
   } chs_t;

   // command from a CS2 write
   typedef struct packed {
      logic                   go;    // single cycle
      logic [`DW_CODE_W-1:0]  code;  // held until the next CS2 write
   } cmd_t;

   // flags kept by the sequencer
   typedef struct packed {
      logic rqa;          // operation done
      logic drq;          // buffer waits for the host
      logic busy;
      logic cmderr;       // bad code or read failure
      logic write_error;  // sticky until reset
   } status_t;

   // interrupt handshake
   typedef enum logic [1:0] {
      irq_idle,
      irq_req,
      irq_wait
   } irq_state_e;

endpackage

// File: source/dw_defs.svh
// register offsets, command codes and id value of the disk controller
// sector size and field widths shared by both packages
`ifndef DW_DEFS_SVH
`define DW_DEFS_SVH

// ********************
// register word offsets, wb_adr_i[4:1]
// ********************
`define DW_REG_ID    4'd0   // id, read only
`define DW_REG_ERR   4'd1   // error flags
`define DW_REG_SEC   4'd3   // sector, 1-based on the bus
`define DW_REG_BUF   4'd4   // data buffer port
`define DW_REG_CYL   4'd5   // cylinder
`define DW_REG_HD    4'd6   // head
`define DW_REG_CS2   4'd7   // command / status 2
`define DW_REG_STRS  4'd8   // status / soft reset

// ********************
// command codes, CS2 bits 7..0
// ********************
`define DW_CMD_RECAL 8'o20  // seek to track 0, nothing to do here
`define DW_CMD_READ  8'o40
`define DW_CMD_WRITE 8'o60

`define DW_ID_VALUE  16'o401

// one sector is 512 bytes
`define DW_SECTOR_WORDS 256

// ********************
// field widths
// ********************
`define DW_WORD_W    16
`define DW_OFF_W     4
`define DW_CODE_W    8
`define DW_BLK_W     27     // block address on the storage side
`define DW_BUF_AW    8      // word address in the sector buffer
`define DW_CYL_W     10     // 1024 cylinders
`define DW_HD_W      3      // 8 heads
`define DW_SEC_W     5      // only 4 bits reach the block address

`endif
